//--- sim.f
common/tlbBistPkg.sv
rtl/marchSequencer/marchSequencer.sv
rtl/expectQueue.sv
rtl/resultChecker.sv
rtl/tlbArrayBist.sv
dv/tlbArrayBist_assertions.sv
dv/tb_tlbArrayBist.sv

//--- run.sh
#!/bin/sh
# build and run the tlb array bist testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_tlbArrayBist -f sim.f -o simTlbArrayBist

simStatus=0
simOut=$(./obj_dir/simTlbArrayBist) || simStatus=$?
printf '%s\n' "$simOut"

if printf '%s\n' "$simOut" | grep -qx "Simulation passed"; then
  exit 0
fi
echo "simulation did not pass, exit status $simStatus"
exit 1

//--- dv/tb_tlbArrayBist.sv
`timescale 1ns/100ps

module tb_tlbArrayBist;
  import tlbBistPkg::*;

  localparam int ClkPeriod    = 40;
  localparam int RunLimit     = 3000;
  localparam int RunCount     = 5;
  localparam int WritesPerRun = 768;
  localparam int ReadsPerRun  = 1024;

  // dut signals
  logic                 clk;
  logic                 rstN_i;
  logic                 startBist_i;
  arrayReqT             arrayReq;
  logic [DataWidth-1:0] readData;
  bistStatusT           status;

  // behavioral array and fault control
  logic [DataWidth-1:0] mem [Depth];
  logic [DataWidth-1:0] rdWord;
  logic                 rdPending;
  logic                 faultEn;
  logic [AddrWidth-1:0] faultAddr;
  logic                 faultBit;
  logic                 faultVal;

  // bookkeeping
  int writeCount;
  int readCount;
  int errorCount;
  int testCount;

  always #(ClkPeriod / 2) clk = ~clk;

  tlbArrayBist u_tlbArrayBist (
    .clk         (clk),
    .rstN_i      (rstN_i),
    .startBist_i (startBist_i),
    .arrayReq_o  (arrayReq),
    .readData_i  (readData),
    .status_o    (status)
  );

  bind tlbArrayBist tlbArrayBist_assertions u_tlbArrayBistAssertions (
    .clk         (clk),
    .rstN_i      (rstN_i),
    .arrayReq_i  (arrayReq_o),
    .pushValid_i (pushValid),
    .popValid_i  (popValid),
    .runStart_i  (runStart),
    .status_i    (status_o)
  );

  // ******************************
  // array model
  // ******************************
  // request sampled mid cycle and read data shows up after the next edge
  always @(negedge clk) begin
    rdPending = arrayReq.rdEn;
    if (arrayReq.rdEn) begin
      rdWord = mem[arrayReq.addr];
      // stuck-at bit only on the faulty entry
      if (faultEn && (arrayReq.addr == faultAddr)) begin
        rdWord[faultBit] = faultVal;
      end
      readCount++;
    end
    if (arrayReq.wrEn) begin
      mem[arrayReq.addr] = arrayReq.data;
      writeCount++;
    end
  end

  always @(posedge clk) begin
    #2;
    if (rdPending) begin
      readData = rdWord;
    end
  end

  // reference pattern that is solid or checkerboard by iteration
  function automatic logic [DataWidth-1:0] patternFor(iterE iter, int addr);
    logic odd;
    odd = (addr % 2) != 0;
    case (iter)
      IterSolid0: return 2'b00;
      IterSolid1: return 2'b11;
      IterCheckA: return odd ? 2'b10 : 2'b01;
      default:    return odd ? 2'b01 : 2'b10;
    endcase
  endfunction

  task automatic reportMismatch(input string name, input string what, input int expVal,
                                input int actVal);
    $display("Mismatch %s: %s expected %0d actual %0d", name, what, expVal, actVal);
    errorCount++;
  endtask

  task automatic finishTest(input string name, input int errBefore);
    testCount++;
    if (errorCount == errBefore) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errorCount - errBefore);
    end
  endtask

  // drop start and wait for done to fall
  task automatic releaseStart(input string name);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #2;
    startBist_i = 1'b0;
    while (status.done && (cycles < 8)) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (status.done) begin
      $display("%s: done stayed high after start was dropped", name);
      errorCount++;
    end
  endtask

  // raise start and wait for done within one run length
  task automatic runToDone(input string name);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #2;
    writeCount  = 0;
    readCount   = 0;
    startBist_i = 1'b1;
    while (!status.done && (cycles < RunLimit)) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!status.done) begin
      $display("%s: done did not rise within %0d cycles", name, RunLimit);
      errorCount++;
    end
  endtask

  // ******************************
  // directed tests
  // ******************************
  task automatic cleanRunTest();
    int errBefore;
    errBefore = errorCount;
    // idle after reset
    if (status.done || status.fail || arrayReq.wrEn || arrayReq.rdEn) begin
      $display("cleanRun: status or strobes not low after reset");
      errorCount++;
    end
    faultEn = 1'b0;
    runToDone("cleanRun");
    if (status.fail !== 1'b0) reportMismatch("cleanRun", "fail", 0, int'(status.fail));
    if (writeCount != WritesPerRun) reportMismatch("cleanRun", "writes", WritesPerRun, writeCount);
    if (readCount != ReadsPerRun) reportMismatch("cleanRun", "reads", ReadsPerRun, readCount);
    finishTest("cleanRun", errBefore);
  endtask

  task automatic finalContentsTest();
    int errBefore;
    errBefore = errorCount;
    // last iteration leaves its own pattern behind
    for (int a = 0; a < Depth; a++) begin
      if (mem[a] !== patternFor(IterCheckB, a)) begin
        reportMismatch("finalContents", $sformatf("entry %0d", a),
                       int'(patternFor(IterCheckB, a)), int'(mem[a]));
      end
    end
    finishTest("finalContents", errBefore);
  endtask

  task automatic stuckAtTest(input string name, input logic stuckVal, input logic keepFault);
    int errBefore;
    errBefore = errorCount;
    releaseStart(name);
    faultAddr = AddrWidth'($urandom % Depth);
    faultBit  = 1'($urandom % DataWidth);
    faultVal  = stuckVal;
    faultEn   = 1'b1;
    runToDone(name);
    if (status.fail !== 1'b1) reportMismatch(name, "fail", 1, int'(status.fail));
    if (status.failAddr !== faultAddr) begin
      reportMismatch(name, "failAddr", int'(faultAddr), int'(status.failAddr));
    end
    faultEn = keepFault;
    finishTest(name, errBefore);
  endtask

  task automatic restartTest();
    int errBefore;
    errBefore = errorCount;
    releaseStart("restart");
    // result of the failing run holds until the new start
    if (status.fail !== 1'b1) reportMismatch("restart", "fail before start", 1, int'(status.fail));
    faultEn = 1'b0;
    runToDone("restart");
    if (status.fail !== 1'b0) reportMismatch("restart", "fail", 0, int'(status.fail));
    // full counts at the first done mean done did not rise early
    if (writeCount != WritesPerRun) reportMismatch("restart", "writes", WritesPerRun, writeCount);
    if (readCount != ReadsPerRun) reportMismatch("restart", "reads", ReadsPerRun, readCount);
    finishTest("restart", errBefore);
  endtask

  // watchdog sized for all runs
  initial begin
    #(RunCount * RunLimit * ClkPeriod);
    $display("watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    clk         = 1'b0;
    rstN_i      = 1'b0;
    startBist_i = 1'b0;
    readData    = '0;
    rdWord      = '0;
    rdPending   = 1'b0;
    faultEn     = 1'b0;
    faultAddr   = '0;
    faultBit    = 1'b0;
    faultVal    = 1'b0;
    writeCount  = 0;
    readCount   = 0;
    errorCount  = 0;
    testCount   = 0;
    void'($urandom(32'hbb943e64));
    // fill depends on every address bit
    for (int i = 0; i < Depth; i++) begin
      mem[i] = DataWidth'(i ^ (i >> 2) ^ (i >> 4));
    end
    repeat (4) @(posedge clk);
    #2;
    rstN_i = 1'b1;

    cleanRunTest();
    finalContentsTest();
    stuckAtTest("stuckAt0", 1'b0, 1'b0);
    stuckAtTest("stuckAt1", 1'b1, 1'b1);
    restartTest();

    $display("%0d tests, %0d errors", testCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- dv/tlbArrayBist_assertions.sv
`timescale 1ns/100ps

module tlbArrayBist_assertions (
  input  logic                   clk,
  input  logic                   rstN_i,
  input  tlbBistPkg::arrayReqT   arrayReq_i,
  input  logic                   pushValid_i,
  input  logic                   popValid_i,
  input  logic                   runStart_i,
  input  tlbBistPkg::bistStatusT status_i
);
  import tlbBistPkg::*;

  // entries in flight, mirrors the queue pointers
  logic [1:0] fillQ;

  // pop is the registered push, so the level never exceeds the depth
  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      fillQ <= '0;
    end else begin
      fillQ <= fillQ + 2'(pushValid_i) - 2'(popValid_i);
    end
  end

  // ******************************
  // strobe and status rules
  // ******************************
  noWriteWithRead: assert property (@(posedge clk) disable iff (!rstN_i)
    !(arrayReq_i.wrEn && arrayReq_i.rdEn))
    else $error("write and read strobes high in the same cycle");

  noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN_i)
    pushValid_i |-> (fillQ < 2'(QueueDepth)))
    else $error("push into a full expectation queue");

  // sticky fail only clears on the start of a new run
  failHeldUntilStart: assert property (@(posedge clk) disable iff (!rstN_i)
    $fell(status_i.fail) |-> $past(runStart_i))
    else $error("fail dropped without a new run start");

endmodule

//--- rtl/tlbArrayBist.sv
`timescale 1ns/100ps

module tlbArrayBist (
  input  logic                             clk,
  input  logic                             rstN_i,
  input  logic                             startBist_i,
  output tlbBistPkg::arrayReqT             arrayReq_o,
  input  logic [tlbBistPkg::DataWidth-1:0] readData_i,
  output tlbBistPkg::bistStatusT           status_o
);
  import tlbBistPkg::*;

  // sequencer to queue
  logic   pushValid;
  expectT pushExpect;

  // queue to checker
  logic   popValid;
  expectT popExpect;

  // run boundaries
  logic   runStart;
  logic   runDone;

  // ******************************
  // producer, buffer, consumer
  // ******************************
  marchSequencer u_marchSequencer (
    .clk          (clk),
    .rstN_i       (rstN_i),
    .startBist_i  (startBist_i),
    .arrayReq_o   (arrayReq_o),
    .pushValid_o  (pushValid),
    .pushExpect_o (pushExpect),
    .runStart_o   (runStart),
    .runDone_o    (runDone)
  );

  expectQueue u_expectQueue (
    .clk          (clk),
    .rstN_i       (rstN_i),
    .pushValid_i  (pushValid),
    .pushExpect_i (pushExpect),
    .popValid_o   (popValid),
    .popExpect_o  (popExpect)
  );

  resultChecker u_resultChecker (
    .clk         (clk),
    .rstN_i      (rstN_i),
    .popValid_i  (popValid),
    .popExpect_i (popExpect),
    .readData_i  (readData_i),
    .runStart_i  (runStart),
    .runDone_i   (runDone),
    .status_o    (status_o)
  );

endmodule

//--- rtl/resultChecker.sv
`timescale 1ns/100ps

module resultChecker (
  input  logic                             clk,
  input  logic                             rstN_i,
  input  logic                             popValid_i,
  input  tlbBistPkg::expectT               popExpect_i,
  input  logic [tlbBistPkg::DataWidth-1:0] readData_i,
  input  logic                             runStart_i,
  input  logic                             runDone_i,
  output tlbBistPkg::bistStatusT           status_o
);
  import tlbBistPkg::*;

  // compare result and status register
  logic       mismatch;
  bistStatusT statusQ;

  // ******************************
  // read compare
  // ******************************
  // read data is only meaningful in the pop cycle
  assign mismatch = popValid_i && (readData_i != popExpect_i.data);

  // ******************************
  // status register
  // ******************************
  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      statusQ <= '0;
    end else begin
      // done follows the sequencer one cycle late
      statusQ.done <= runDone_i;
      if (runStart_i) begin
        // new run wipes the previous result
        statusQ.fail     <= 1'b0;
        statusQ.failAddr <= '0;
      end else if (mismatch && !statusQ.fail) begin
        // sticky, keep the first failing address only
        statusQ.fail     <= 1'b1;
        statusQ.failAddr <= popExpect_i.addr;
      end
    end
  end

  assign status_o = statusQ;

endmodule

//--- rtl/expectQueue.sv
`timescale 1ns/100ps

module expectQueue (
  input  logic               clk,
  input  logic               rstN_i,
  input  logic               pushValid_i,
  input  tlbBistPkg::expectT pushExpect_i,
  output logic               popValid_o,
  output tlbBistPkg::expectT popExpect_o
);
  import tlbBistPkg::*;

  // storage and pointers, top pointer bit is the wrap flag
  expectT                 entryQ [QueueDepth];
  logic [QueuePtrWidth:0] wrPtrQ;
  logic [QueuePtrWidth:0] rdPtrQ;
  logic                   queueFull;
  logic                   queueEmpty;
  logic                   pushEn;
  logic                   popEn;

  // ******************************
  // occupancy
  // ******************************
  assign queueEmpty = (wrPtrQ == rdPtrQ);
  assign queueFull  = (wrPtrQ[QueuePtrWidth] != rdPtrQ[QueuePtrWidth]) &&
                      (wrPtrQ[QueuePtrWidth-1:0] == rdPtrQ[QueuePtrWidth-1:0]);

  // read spacing keeps the queue from filling up
  assign pushEn = pushValid_i && !queueFull;
  assign popEn  = popValid_o && !queueEmpty;

  always_ff @(posedge clk) begin
    if (pushEn) begin
      entryQ[wrPtrQ[QueuePtrWidth-1:0]] <= pushExpect_i;
    end
  end

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      wrPtrQ     <= '0;
      rdPtrQ     <= '0;
      popValid_o <= 1'b0;
    end else begin
      if (pushEn) begin
        wrPtrQ <= wrPtrQ + 1'b1;
      end
      if (popEn) begin
        rdPtrQ <= rdPtrQ + 1'b1;
      end
      // retire one cycle after the push, same as the array latency
      popValid_o <= pushEn;
    end
  end

  // oldest entry goes to the checker
  assign popExpect_o = entryQ[rdPtrQ[QueuePtrWidth-1:0]];

endmodule

//--- rtl/marchSequencer/marchSequencer.sv
`timescale 1ns/100ps

module marchSequencer (
  input  logic                 clk,
  input  logic                 rstN_i,
  input  logic                 startBist_i,
  output tlbBistPkg::arrayReqT arrayReq_o,
  output logic                 pushValid_o,
  output tlbBistPkg::expectT   pushExpect_o,
  output logic                 runStart_o,
  output logic                 runDone_o
);
  import tlbBistPkg::*;

  // state and counters
  bistStateE            stateQ;
  bistStateE            stateD;
  logic [AddrWidth-1:0] addrQ;
  logic [AddrWidth-1:0] addrD;
  logic                 decrementQ;
  logic                 decrementD;
  iterE                 iterQ;
  iterE                 iterD;

  // derived controls
  logic                 cntZero;
  logic                 cntDone;
  logic [AddrWidth-1:0] addrStep;
  logic                 invert;
  logic [DataWidth-1:0] reqData;
  logic                 isWrite;
  logic                 isRead;

  // iteration order 00 -> 11 -> 01 -> 10 -> 00
  function automatic iterE nextIter(iterE cur);
    iterE nxt;
    unique case (cur)
      IterSolid0: nxt = IterSolid1;
      IterSolid1: nxt = IterCheckA;
      IterCheckA: nxt = IterCheckB;
      default:    nxt = IterSolid0;
    endcase
    return nxt;
  endfunction

  // ******************************
  // address counter
  // ******************************
  assign cntZero = (addrQ == '0);
  assign cntDone = (addrQ == MaxAddr);

  // one adder for both directions
  // complement before and after the increment to count down
  assign addrStep = ((addrQ ^ {AddrWidth{decrementQ}}) + 1'b1) ^ {AddrWidth{decrementQ}};

  // ******************************
  // next state
  // ******************************
  always_comb begin
    stateD     = stateQ;
    addrD      = addrQ;
    decrementD = decrementQ;
    iterD      = iterQ;
    unique case (stateQ)
      Idle: begin
        // fresh run starts at address 0 in the first iteration
        if (startBist_i) begin
          stateD     = Write0;
          addrD      = '0;
          decrementD = 1'b0;
          iterD      = IterSolid0;
        end
      end
      Write0: begin
        // fill pass, one write per cycle
        if (cntDone) begin
          stateD = Read0;
          addrD  = '0;
        end else begin
          addrD = addrStep;
        end
      end
      Read0:  stateD = Comp0;
      Comp0:  stateD = Write1;
      Write1: stateD = Read1;
      Read1:  stateD = Comp1;
      Comp1: begin
        if (!decrementQ) begin
          // ascending march, top address turns the direction around
          stateD = Read0;
          if (cntDone) begin
            decrementD = 1'b1;
          end else begin
            addrD = addrStep;
          end
        end else if (!cntZero) begin
          stateD = Read0;
          addrD  = addrStep;
        end else begin
          // descending march finished this iteration
          decrementD = 1'b0;
          iterD      = nextIter(iterQ);
          stateD     = (iterQ == IterCheckB) ? Done : Write0;
        end
      end
      Done: begin
        // hold until the start level drops
        if (!startBist_i) begin
          stateD = Idle;
        end
      end
      default: stateD = Idle;
    endcase
  end

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      stateQ     <= Idle;
      addrQ      <= '0;
      decrementQ <= 1'b0;
      iterQ      <= IterSolid0;
    end else begin
      stateQ     <= stateD;
      addrQ      <= addrD;
      decrementQ <= decrementD;
      iterQ      <= iterD;
    end
  end

  // ******************************
  // array request and expectation
  // ******************************
  assign isWrite = (stateQ == Write0) || (stateQ == Write1);
  assign isRead  = (stateQ == Read0) || (stateQ == Read1);

  // second read and its write are inverted on the way up
  // on the way down the first read is the inverted one
  // decrement is always low during the fill pass
  assign invert  = decrementQ ^ ((stateQ == Write1) || (stateQ == Read1));
  assign reqData = basePattern(iterQ, addrQ[0]) ^ {DataWidth{invert}};

  always_comb begin
    arrayReq_o.wrEn = isWrite;
    arrayReq_o.rdEn = isRead;
    arrayReq_o.addr = addrQ;
    arrayReq_o.data = reqData;
  end

  // every read pushes what it should return
  assign pushValid_o       = isRead;
  assign pushExpect_o.addr = addrQ;
  assign pushExpect_o.data = reqData;

  // run boundaries for the checker
  assign runStart_o = (stateQ == Idle) && startBist_i;
  assign runDone_o  = (stateQ == Done);

endmodule

//--- common/tlbBistPkg.sv
package tlbBistPkg;

  // array geometry
  localparam int AddrWidth = 6;
  localparam int Depth     = 64;
  localparam int DataWidth = 2;

  // last address of the array
  localparam logic [AddrWidth-1:0] MaxAddr = AddrWidth'(Depth - 1);

  // expectation queue sizing
  // one pointer bit per entry index plus a wrap bit
  localparam int QueueDepth    = 2;
  localparam int QueuePtrWidth = 1;

  // ******************************
  // march state encoding
  // ******************************
  typedef enum logic [2:0] {
    Idle   = 3'd0,
    Write0 = 3'd1,
    Read0  = 3'd2,
    Comp0  = 3'd3,
    Write1 = 3'd4,
    Read1  = 3'd5,
    Comp1  = 3'd6,
    Done   = 3'd7
  } bistStateE;

  // iteration order is 00 -> 11 -> 01 -> 10
  // the encoding doubles as the base data pattern
  typedef enum logic [1:0] {
    IterSolid0 = 2'b00,
    IterSolid1 = 2'b11,
    IterCheckA = 2'b01,
    IterCheckB = 2'b10
  } iterE;

  // request to the external array
  typedef struct packed {
    logic                 wrEn;
    logic                 rdEn;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] data;
  } arrayReqT;

  // expected result of one read in flight
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] data;
  } expectT;

  // engine status seen at the top
  typedef struct packed {
    logic                 done;
    logic                 fail;
    logic [AddrWidth-1:0] failAddr;
  } bistStatusT;

  // base pattern for an iteration and address
  // solid iterations ignore the address
  // checkerboard iterations flip on odd addresses
  function automatic logic [DataWidth-1:0] basePattern(iterE iter, logic addrLsb);
    logic [DataWidth-1:0] base;
    logic                 isCheck;
    base    = iter;
    isCheck = base[1] ^ base[0];
    return base ^ {DataWidth{isCheck & addrLsb}};
  endfunction

endpackage
